// File: include/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

`define XLEN           64
`define REG_ADDR_WIDTH 5
`define REG_COUNT      32

// rv64i major opcodes
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LUI     7'b0110111
`define OPC_BRANCH  7'b1100011
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111

`endif

// File: rtl/rv_pkg.sv
`include "rv_consts.svh"

package rv_pkg;

    typedef logic [`XLEN-1:0]           xlen_t;
    typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;

    // alu ops, the last four are the branch compares
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_EQ,
        ALU_NE,
        ALU_LT,
        ALU_GE
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC_REG, // rs1 op rs2
        SRC_IMM, // rs1 op imm
        SRC_LUI  // zero + imm
    } alu_src_e;

    typedef struct packed {
        xlen_t     pc;
        xlen_t     rs1_data;
        xlen_t     rs2_data;
        xlen_t     imm;
        alu_op_e   alu_op;
        alu_src_e  alu_src;
        reg_addr_t rd;
        logic      reg_wen;
        logic      branch;
        logic      jump;     // jal and jalr
        logic      jalr;
        logic      illegal;
    } id_ex_t;

    typedef struct packed {
        xlen_t     pc;
        reg_addr_t rd;
        logic      reg_wen;
        xlen_t     wdata;
        logic      redirect;
        xlen_t     redirect_pc;
        logic      illegal;
    } ex_wb_t;

endpackage

// File: rtl/rf_read_if.sv
`timescale 1ns/1ps

interface rf_read_if;
    import rv_pkg::*;

    reg_addr_t raddr1;
    reg_addr_t raddr2;
    xlen_t     rdata1;
    xlen_t     rdata2;

    // decode side
    modport requester (output raddr1, output raddr2, input rdata1, input rdata2);

    // register file side, answers in the same cycle
    modport responder (input raddr1, input raddr2, output rdata1, output rdata2);

endinterface

// File: rtl/reg_file.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module reg_file (
    input  logic              clk,
    input  logic              rst_n,
    rf_read_if.responder      rf,
    input  logic              we_i,
    input  rv_pkg::reg_addr_t waddr_i,
    input  rv_pkg::xlen_t     wdata_i
);
    import rv_pkg::*;

    xlen_t regs [1:`REG_COUNT-1]; // no storage for x0

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // combinational reads, x0 reads as zero
    assign rf.rdata1 = (rf.raddr1 == '0) ? '0 : regs[rf.raddr1];
    assign rf.rdata2 = (rf.raddr2 == '0) ? '0 : regs[rf.raddr2];

endmodule

// File: rtl/id_decode.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module id_decode (
    input  logic [31:0]    instr_i,
    input  rv_pkg::xlen_t  pc_i,
    rf_read_if.requester   rf,
    output rv_pkg::id_ex_t payload_o,
    output logic           rs1_used_o,
    output logic           rs2_used_o
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;      // instr[30], selects sub and sra
    reg_addr_t  rd;
    xlen_t      imm_i;
    xlen_t      imm_b;
    xlen_t      imm_j;
    xlen_t      imm_u;
    alu_op_e    arith_op;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign alt    = instr_i[30];
    assign rd     = instr_i[11:7];

    // both sources are read for every format
    assign rf.raddr1 = instr_i[19:15];
    assign rf.raddr2 = instr_i[24:20];

    assign imm_i = {{52{instr_i[31]}}, instr_i[31:20]};
    assign imm_b = {{52{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm_j = {{44{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
    assign imm_u = {{32{instr_i[31]}}, instr_i[31:12], 12'h000};

    // funct3 map shared by op and op-imm, sub exists only in op
    always_comb begin
        case (funct3)
            3'b000:  arith_op = (alt && (opcode == `OPC_OP)) ? ALU_SUB : ALU_ADD;
            3'b001:  arith_op = ALU_SLL;
            3'b010:  arith_op = ALU_SLT;
            3'b011:  arith_op = ALU_SLTU;
            3'b100:  arith_op = ALU_XOR;
            3'b101:  arith_op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    end

    always_comb begin
        payload_o          = '0;
        payload_o.pc       = pc_i;
        payload_o.rs1_data = rf.rdata1;
        payload_o.rs2_data = rf.rdata2;
        payload_o.rd       = rd;
        payload_o.alu_op   = arith_op;
        payload_o.alu_src  = SRC_REG;
        rs1_used_o         = 1'b0;
        rs2_used_o         = 1'b0;
        case (opcode)
            `OPC_OP: begin
                payload_o.reg_wen = 1'b1;
                rs1_used_o        = 1'b1;
                rs2_used_o        = 1'b1;
            end
            `OPC_OP_IMM: begin
                payload_o.imm     = imm_i;
                payload_o.alu_src = SRC_IMM;
                payload_o.reg_wen = 1'b1;
                rs1_used_o        = 1'b1;
            end
            `OPC_LUI: begin
                payload_o.imm     = imm_u;
                payload_o.alu_op  = ALU_ADD;
                payload_o.alu_src = SRC_LUI;
                payload_o.reg_wen = 1'b1;
            end
            `OPC_BRANCH: begin
                payload_o.imm    = imm_b;
                payload_o.branch = 1'b1;
                rs1_used_o       = 1'b1;
                rs2_used_o       = 1'b1;
                case (funct3)
                    3'b000:  payload_o.alu_op = ALU_EQ;
                    3'b001:  payload_o.alu_op = ALU_NE;
                    3'b100:  payload_o.alu_op = ALU_LT;
                    3'b101:  payload_o.alu_op = ALU_GE;
                    default: payload_o.illegal = 1'b1; // bltu and bgeu are left out
                endcase
            end
            `OPC_JAL: begin
                payload_o.imm     = imm_j;
                payload_o.jump    = 1'b1;
                payload_o.reg_wen = 1'b1;
            end
            `OPC_JALR: begin
                payload_o.imm     = imm_i;
                payload_o.jump    = 1'b1;
                payload_o.jalr    = 1'b1;
                payload_o.reg_wen = 1'b1;
                rs1_used_o        = 1'b1;
            end
            default: begin
                payload_o.illegal = 1'b1; // retires without a write
            end
        endcase
        // x0 as destination never writes
        if (rd == '0) begin
            payload_o.reg_wen = 1'b0;
        end
    end

endmodule

// File: rtl/hazard_ctrl.sv
`timescale 1ns/1ps

module hazard_ctrl (
    input  logic              instr_valid_i,
    input  rv_pkg::reg_addr_t rs1_i,
    input  rv_pkg::reg_addr_t rs2_i,
    input  logic              rs1_used_i,
    input  logic              rs2_used_i,
    input  logic              ex_valid_i,
    input  rv_pkg::reg_addr_t ex_rd_i,
    input  logic              ex_wen_i,
    input  logic              ex_ctrl_i,   // branch or jump in id/ex
    output logic              instr_ready_o,
    output logic              accept_o
);

    logic raw_hit;
    logic ctrl_hit;

    // producer still in id/ex, its result reaches the rf on the next edge
    assign raw_hit = ex_valid_i && ex_wen_i && (ex_rd_i != '0) &&
                     ((rs1_used_i && (rs1_i == ex_rd_i)) ||
                      (rs2_used_i && (rs2_i == ex_rd_i)));

    // wait for the redirect before taking the next pc
    assign ctrl_hit = ex_valid_i && ex_ctrl_i;

    assign instr_ready_o = !(raw_hit || ctrl_hit);
    assign accept_o      = instr_valid_i && instr_ready_o; // loads id/ex

endmodule

// File: rtl/pipe_stage_reg.sv
`timescale 1ns/1ps

module pipe_stage_reg #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     load_i,
    input  payload_t data_i,
    output logic     valid_o,
    output payload_t data_o
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= load_i; // low means bubble
        end
    end

    // payload holds its old value across a bubble
    always_ff @(posedge clk) begin
        if (load_i) begin
            data_o <= data_i;
        end
    end

endmodule

// File: rtl/ex_alu.sv
`timescale 1ns/1ps

module ex_alu (
    input  rv_pkg::id_ex_t stage_i,
    output rv_pkg::ex_wb_t payload_o
);
    import rv_pkg::*;

    xlen_t    op_a;
    xlen_t    op_b;
    xlen_t    alu_res;
    xlen_t    br_target;
    xlen_t    jalr_sum;
    logic [5:0] shamt;
    logic     cmp_taken;

    assign op_a  = (stage_i.alu_src == SRC_LUI) ? '0 : stage_i.rs1_data;
    assign op_b  = (stage_i.alu_src == SRC_REG) ? stage_i.rs2_data : stage_i.imm;
    assign shamt = op_b[5:0]; // rv64 shifts use 6 bits

    always_comb begin
        alu_res   = '0;
        cmp_taken = 1'b0;
        case (stage_i.alu_op)
            ALU_ADD:  alu_res = op_a + op_b;
            ALU_SUB:  alu_res = op_a - op_b;
            ALU_AND:  alu_res = op_a & op_b;
            ALU_OR:   alu_res = op_a | op_b;
            ALU_XOR:  alu_res = op_a ^ op_b;
            ALU_SLL:  alu_res = op_a << shamt;
            ALU_SRL:  alu_res = op_a >> shamt;
            ALU_SRA:  alu_res = xlen_t'($signed(op_a) >>> shamt);
            ALU_SLT:  alu_res = {63'd0, ($signed(op_a) < $signed(op_b))};
            ALU_SLTU: alu_res = {63'd0, (op_a < op_b)};
            ALU_EQ:   cmp_taken = (op_a == op_b);
            ALU_NE:   cmp_taken = (op_a != op_b);
            ALU_LT:   cmp_taken = ($signed(op_a) < $signed(op_b));
            ALU_GE:   cmp_taken = ($signed(op_a) >= $signed(op_b));
            default:  alu_res = '0;
        endcase
    end

    assign br_target = stage_i.pc + stage_i.imm;      // branch and jal
    assign jalr_sum  = stage_i.rs1_data + stage_i.imm;

    always_comb begin
        payload_o.pc       = stage_i.pc;
        payload_o.rd       = stage_i.rd;
        payload_o.reg_wen  = stage_i.reg_wen;
        payload_o.illegal  = stage_i.illegal;
        payload_o.redirect = stage_i.jump || (stage_i.branch && cmp_taken);
        if (stage_i.jalr) begin
            payload_o.redirect_pc = {jalr_sum[63:1], 1'b0};
        end else begin
            payload_o.redirect_pc = br_target;
        end
        // link address for jumps
        payload_o.wdata = stage_i.jump ? (stage_i.pc + 64'd4) : alu_res;
    end

endmodule

// File: rtl/rv_exec_top.sv
`timescale 1ns/1ps

module rv_exec_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              instr_valid_i,
    input  logic [31:0]       instr_i,
    input  rv_pkg::xlen_t     pc_i,
    output logic              instr_ready_o,
    output logic              wb_valid_o,
    output rv_pkg::xlen_t     wb_pc_o,
    output rv_pkg::reg_addr_t wb_rd_o,
    output logic              wb_we_o,
    output rv_pkg::xlen_t     wb_data_o,
    output logic              wb_illegal_o,
    output logic              redirect_valid_o,
    output rv_pkg::xlen_t     redirect_pc_o
);
    import rv_pkg::*;

    id_ex_t id_ex_d;
    id_ex_t id_ex_q;
    ex_wb_t ex_wb_d;
    ex_wb_t ex_wb_q;
    logic   id_ex_valid;
    logic   ex_wb_valid;
    logic   accept;
    logic   rs1_used;
    logic   rs2_used;

    rf_read_if rf_rd ();

    id_decode u_decode (
        .instr_i    (instr_i),
        .pc_i       (pc_i),
        .rf         (rf_rd),
        .payload_o  (id_ex_d),
        .rs1_used_o (rs1_used),
        .rs2_used_o (rs2_used)
    );

    hazard_ctrl u_hazard (
        .instr_valid_i (instr_valid_i),
        .rs1_i         (rf_rd.raddr1),
        .rs2_i         (rf_rd.raddr2),
        .rs1_used_i    (rs1_used),
        .rs2_used_i    (rs2_used),
        .ex_valid_i    (id_ex_valid),
        .ex_rd_i       (id_ex_q.rd),
        .ex_wen_i      (id_ex_q.reg_wen),
        .ex_ctrl_i     (id_ex_q.branch | id_ex_q.jump),
        .instr_ready_o (instr_ready_o),
        .accept_o      (accept)
    );

    pipe_stage_reg #(.payload_t(id_ex_t)) u_id_ex (
        .clk     (clk),
        .rst_n   (rst_n),
        .load_i  (accept),
        .data_i  (id_ex_d),
        .valid_o (id_ex_valid),
        .data_o  (id_ex_q)
    );

    ex_alu u_alu (
        .stage_i   (id_ex_q),
        .payload_o (ex_wb_d)
    );

    pipe_stage_reg #(.payload_t(ex_wb_t)) u_ex_wb (
        .clk     (clk),
        .rst_n   (rst_n),
        .load_i  (id_ex_valid),
        .data_i  (ex_wb_d),
        .valid_o (ex_wb_valid),
        .data_o  (ex_wb_q)
    );

    // written on the same edge that loads ex/wb
    reg_file u_rf (
        .clk     (clk),
        .rst_n   (rst_n),
        .rf      (rf_rd),
        .we_i    (id_ex_valid & ex_wb_d.reg_wen),
        .waddr_i (ex_wb_d.rd),
        .wdata_i (ex_wb_d.wdata)
    );

    // stale payload behind a bubble must not show
    assign wb_valid_o       = ex_wb_valid;
    assign wb_pc_o          = ex_wb_q.pc;
    assign wb_rd_o          = ex_wb_q.rd;
    assign wb_we_o          = ex_wb_valid & ex_wb_q.reg_wen;
    assign wb_data_o        = ex_wb_q.wdata;
    assign wb_illegal_o     = ex_wb_valid & ex_wb_q.illegal;
    assign redirect_valid_o = ex_wb_valid & ex_wb_q.redirect;
    assign redirect_pc_o    = ex_wb_q.redirect_pc;

endmodule

// File: tb/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen (
    output logic clk_o,
    output logic rst_n_o
);

    // 4 ns period
    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (2) @(posedge clk_o);
        @(negedge clk_o) rst_n_o = 1'b1; // release between edges
    end

endmodule

// File: tb/tb_rv_exec.sv
`timescale 1ns/1ps

module tb_rv_exec;
    import rv_pkg::*;

    localparam int MAX_INSTR  = 64;
    localparam int WAIT_LIMIT = 50;

    logic        clk;
    logic        rst_n;
    logic        instr_valid;
    logic [31:0] instr;
    xlen_t       pc;
    logic        instr_ready;
    logic        wb_valid;
    xlen_t       wb_pc;
    reg_addr_t   wb_rd;
    logic        wb_we;
    xlen_t       wb_data;
    logic        wb_illegal;
    logic        redirect_valid;
    xlen_t       redirect_pc;

    // instruction stream and expected retire records
    xlen_t       in_pc      [MAX_INSTR];
    logic [31:0] in_word    [MAX_INSTR];
    xlen_t       exp_pc     [MAX_INSTR];
    reg_addr_t   exp_rd     [MAX_INSTR];
    logic        exp_we     [MAX_INSTR];
    xlen_t       exp_data   [MAX_INSTR];
    logic        exp_redir  [MAX_INSTR];
    xlen_t       exp_target [MAX_INSTR];
    logic        exp_ill    [MAX_INSTR];
    int          n_in;
    int          n_exp;
    int          n_ret;
    int          mismatch_cnt;
    int          other_cnt;
    logic [15:0] lfsr;
    bit          stop_run;

    tb_clkgen u_clkgen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    rv_exec_top dut (
        .clk              (clk),
        .rst_n            (rst_n),
        .instr_valid_i    (instr_valid),
        .instr_i          (instr),
        .pc_i             (pc),
        .instr_ready_o    (instr_ready),
        .wb_valid_o       (wb_valid),
        .wb_pc_o          (wb_pc),
        .wb_rd_o          (wb_rd),
        .wb_we_o          (wb_we),
        .wb_data_o        (wb_data),
        .wb_illegal_o     (wb_illegal),
        .redirect_valid_o (redirect_valid),
        .redirect_pc_o    (redirect_pc)
    );

    // galois form, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    task automatic next_gap(output int gap);
        int g;
        g = 0;
        for (int b = 0; b < 2; b++) begin
            lfsr = lfsr_step(lfsr); // one step per bit
            g = (g << 1) | int'(lfsr[0]);
        end
        gap = (g == 3) ? 1 : g;   // fold to 0..2
    endtask

    task automatic check_data(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            mismatch_cnt++;
        end
    endtask

    task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            mismatch_cnt++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            mismatch_cnt++;
        end
    endtask

    task automatic load_cases();
        int          fd;
        int          n;
        string       line;
        logic [63:0] a, d, t;
        logic [31:0] w, rd, we, rdir, ill;
        n_in  = 0;
        n_exp = 0;
        fd = $fopen("tb/exec_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open tb/exec_cases.txt");
            other_cnt++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") begin
                n = 0; // comment or blank
            end else if (line.getc(0) == "I" && n_in < MAX_INSTR) begin
                n = $sscanf(line, "I %h %h", a, w);
                if (n != 2) begin
                    $display("malformed instruction line in cases file: %s", line);
                    other_cnt++;
                end
                in_pc[n_in]   = a;
                in_word[n_in] = w;
                n_in++;
            end else if (line.getc(0) == "E" && n_exp < MAX_INSTR) begin
                n = $sscanf(line, "E %h %h %h %h %h %h %h", a, rd, we, d, rdir, t, ill);
                if (n != 7) begin
                    $display("malformed record line in cases file: %s", line);
                    other_cnt++;
                end
                exp_pc[n_exp]     = a;
                exp_rd[n_exp]     = rd[4:0];
                exp_we[n_exp]     = we[0];
                exp_data[n_exp]   = d;
                exp_redir[n_exp]  = rdir[0];
                exp_target[n_exp] = t;
                exp_ill[n_exp]    = ill[0];
                n_exp++;
            end
        end
        $fclose(fd);
    endtask

    // holds the instruction until the handshake completes
    task automatic offer_instr(input int idx);
        int waited;
        bit accepted;
        waited   = 0;
        accepted = 1'b0;
        instr_valid = 1'b1;
        instr       = in_word[idx];
        pc          = in_pc[idx];
        while (!accepted && !stop_run) begin
            #1;                       // ready has settled, rising edge still ahead
            accepted = instr_ready;
            @(negedge clk);
            waited++;
            if (!accepted && waited > WAIT_LIMIT) begin
                $display("instruction at pc %h was not accepted within %0d cycles", pc, waited);
                other_cnt++;
                stop_run = 1'b1;
            end
        end
    endtask

    task automatic check_retire();
        if (n_ret >= n_exp) begin
            $display("unexpected retire at pc %h after all expected records", wb_pc);
            other_cnt++;
        end else begin
            check_data("wb_pc_o", wb_pc, exp_pc[n_ret]);
            check_flag("wb_we_o", wb_we, exp_we[n_ret]);
            check_flag("wb_illegal_o", wb_illegal, exp_ill[n_ret]);
            check_flag("redirect_valid_o", redirect_valid, exp_redir[n_ret]);
            if (exp_we[n_ret]) begin
                check_reg("wb_rd_o", wb_rd, exp_rd[n_ret]);
                check_data("wb_data_o", wb_data, exp_data[n_ret]);
            end
            if (exp_redir[n_ret]) begin
                check_data("redirect_pc_o", redirect_pc, exp_target[n_ret]);
            end
        end
        n_ret++;
    endtask

    // retire outputs are stable around the falling edge
    always @(negedge clk) begin
        if (rst_n === 1'b1 && wb_valid === 1'b1) begin
            check_retire();
        end else if (rst_n === 1'b1 && (wb_we | wb_illegal | redirect_valid) !== 1'b0) begin
            $display("retire flags active while wb_valid_o is low");
            other_cnt++;
        end
    end

    initial begin
        int gap;
        int waited;
        instr_valid  = 1'b0;
        instr        = '0;
        pc           = '0;
        lfsr         = 16'd19;
        stop_run     = 1'b0;
        mismatch_cnt = 0;
        other_cnt    = 0;
        n_ret        = 0;
        load_cases();
        if (n_in == 0 || n_in != n_exp) begin
            $display("cases file holds %0d instructions but %0d records", n_in, n_exp);
            other_cnt++;
            stop_run = 1'b1;
        end

        waited = 0;
        while (rst_n !== 1'b1 && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (rst_n !== 1'b1) begin
            $display("reset was never released");
            other_cnt++;
            stop_run = 1'b1;
        end
        @(negedge clk);
        check_flag("instr_ready_o", instr_ready, 1'b1); // idle pipe after reset
        check_flag("wb_valid_o", wb_valid, 1'b0);
        check_flag("wb_illegal_o", wb_illegal, 1'b0);
        check_flag("redirect_valid_o", redirect_valid, 1'b0);

        for (int i = 0; i < n_in && !stop_run; i++) begin
            next_gap(gap);
            instr_valid = 1'b0;
            repeat (gap) @(negedge clk);
            offer_instr(i);
        end
        instr_valid = 1'b0;

        waited = 0;
        while (n_ret < n_exp && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (n_ret < n_exp) begin
            $display("only %0d of %0d records retired before the timeout", n_ret, n_exp);
            other_cnt++;
        end
        repeat (4) @(negedge clk); // catch retires beyond the stream
        @(posedge clk);

        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: tb/exec_cases.txt
# I pc instr
# E pc rd we data redirect target illegal
I 00 00500093
I 04 ffd00113
I 08 402081b3
I 0c 40115233
I 10 001122b3
I 14 00113333
I 18 123453b7
I 1c 00708013
I 20 00108463
I 28 00109463
I 2c 00114463
I 34 0020d463
I 3c 0080046f
I 44 009404e7
I 48 00700533
I 4c 00000000
E 00 01 1 0000000000000005 0 00 0
E 04 02 1 fffffffffffffffd 0 00 0
E 08 03 1 0000000000000008 0 00 0
E 0c 04 1 ffffffffffffffff 0 00 0
E 10 05 1 0000000000000001 0 00 0
E 14 06 1 0000000000000000 0 00 0
E 18 07 1 0000000012345000 0 00 0
E 1c 00 0 000000000000000c 0 00 0
E 20 00 0 0000000000000000 1 28 0
E 28 00 0 0000000000000000 0 00 0
E 2c 00 0 0000000000000000 1 34 0
E 34 00 0 0000000000000000 1 3c 0
E 3c 08 1 0000000000000040 1 44 0
E 44 09 1 0000000000000048 1 48 0
E 48 0a 1 0000000012345000 0 00 0
E 4c 00 0 0000000000000000 0 00 1

// File: src.f
+incdir+include
rtl/rv_pkg.sv
rtl/rf_read_if.sv
rtl/reg_file.sv
rtl/id_decode.sv
rtl/hazard_ctrl.sv
rtl/pipe_stage_reg.sv
rtl/ex_alu.sv
rtl/rv_exec_top.sv
tb/tb_clkgen.sv
tb/tb_rv_exec.sv

// File: run_sim.sh
#!/bin/sh
# build and run the rv_exec testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f src.f --top-module tb_rv_exec -o tb_rv_exec
./obj_dir/tb_rv_exec | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    exit 1
fi
exit 0
